// ==== dcache_ram.f ====
logic/dcache_pkg.sv
logic/dcache_wr_if.sv
logic/dcache_rd_if.sv
logic/dcache_write_path.sv
logic/dcache_arrays.sv
logic/dcache_read_format.sv
logic/dcache_ram.sv
dv/dcache_ram_assertions.sv
dv/tb_dcache_ram.sv

// ==== Makefile ====
# Verilator build for the data cache ram testbench

TOOL       := verilator
TOP        := tb_dcache_ram
FILELIST   := dcache_ram.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and pass only if the pass line shows up
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== dv/tb_dcache_ram.sv ====
// --------------------
// testbench for the data cache ram
// directed and random traffic on all ports, checked against a model
// --------------------
`timescale 1ns/10ps

module tb_dcache_ram;
  import dcache_pkg::*;

  localparam int num_cycles = 4000;   // random phase length
  localparam int wait_limit = 16;     // edges before a wait gives up

  logic        gclk;
  logic        rst_n;
  tid_t        iu_rd_tid;
  half_idx_t   iu_rd_index;
  tid_t        iu_wr_tid;
  half_idx_t   iu_wr_index;
  half_data_t  iu_wdata;
  half_mask_t  iu_we_data;
  logic        iu_we_tag;
  tag_entry_t  iu_wtag;
  tid_t        mem_rd_tid;
  half_idx_t   mem_rd_index;
  tid_t        mem_wr_tid;
  half_idx_t   mem_wr_index;
  half_data_t  mem_wdata;
  logic        mem_wr_beat;
  logic        mem_tag_we;
  tag_t        mem_wtag;
  half_data_t  iu_rdata;
  tag_entry_t  iu_rtag;
  half_data_t  mem_rdata;

  // --------------------
  // reference model state
  line_data_t  m_data [num_lines];
  tag_entry_t  m_tag  [num_lines];
  logic        m_phase;        // next beat is the high half
  logic        m_pend;         // line write at this edge
  half_data_t  m_lo;
  line_data_t  m_fill_line;
  line_addr_t  m_fill_addr;
  half_data_t  exp_iu_rdata;
  tag_entry_t  exp_iu_rtag;
  half_data_t  exp_mem_rdata;
  logic        check_en;       // off until every line holds known data
  int          errors;
  int          timeouts;
  integer      seed;

  dcache_ram u_dut (
    .gclk (gclk), .rst_n (rst_n),
    .iu_rd_tid (iu_rd_tid), .iu_rd_index (iu_rd_index),
    .iu_wr_tid (iu_wr_tid), .iu_wr_index (iu_wr_index), .iu_wdata (iu_wdata),
    .iu_we_data (iu_we_data), .iu_we_tag (iu_we_tag), .iu_wtag (iu_wtag),
    .mem_rd_tid (mem_rd_tid), .mem_rd_index (mem_rd_index),
    .mem_wr_tid (mem_wr_tid), .mem_wr_index (mem_wr_index), .mem_wdata (mem_wdata),
    .mem_wr_beat (mem_wr_beat), .mem_tag_we (mem_tag_we), .mem_wtag (mem_wtag),
    .iu_rdata (iu_rdata), .iu_rtag (iu_rtag), .mem_rdata (mem_rdata)
  );

  initial begin
    gclk = 1'b0;
    forever #4 gclk = ~gclk;    // 8 ns period
  end

  function automatic half_data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic tid_t tid_of(input line_addr_t a);
    return a[6:5];
  endfunction

  function automatic half_idx_t index_of(input line_addr_t a, input logic h);
    return {a[4:0], h};        // h is the half bit
  endfunction

  task automatic check_word(input string name, input half_data_t exp, input half_data_t act);
    assert (act === exp) else begin
      errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input tag_entry_t exp, input tag_entry_t act);
    assert (act === exp) else begin
      errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // --------------------
  // one rising edge of the model, reads before writes
  task automatic model_edge();
    line_addr_t ra;
    line_addr_t ma;
    line_addr_t wa;
    ra = {iu_rd_tid, iu_rd_index[5:1]};
    ma = {mem_rd_tid, mem_rd_index[5:1]};
    wa = {iu_wr_tid, iu_wr_index[5:1]};
    exp_iu_rdata  = iu_rd_index[0] ? m_data[ra][127:64] : m_data[ra][63:0];
    exp_iu_rtag   = m_tag[ra];
    exp_mem_rdata = mem_rd_index[0] ? m_data[ma][127:64] : m_data[ma][63:0];
    if (m_pend) begin
      m_data[m_fill_addr] = m_fill_line;     // iu data write dropped
    end else begin
      if (iu_we_data[0]) m_data[wa][63:0]   = iu_wdata;
      if (iu_we_data[1]) m_data[wa][127:64] = iu_wdata;
    end
    if (mem_tag_we) begin
      m_tag[{mem_wr_tid, mem_wr_index[5:1]}] = {3'b000, mem_wtag};
    end else if (iu_we_tag) begin
      m_tag[wa] = iu_wtag;
    end
    m_pend = mem_wr_beat && m_phase;
    if (mem_wr_beat) begin
      if (!m_phase) begin
        m_lo = mem_wdata;
      end else begin
        m_fill_line = {mem_wdata, m_lo};
        m_fill_addr = {mem_wr_tid, mem_wr_index[5:1]};
      end
      m_phase = !m_phase;
    end
  endtask

  // edge, model update, then compare once outputs settle
  task automatic step();
    @(posedge gclk);
    model_edge();
    #1;
    if (check_en) begin
      check_word("iu_rdata", exp_iu_rdata, iu_rdata);
      check_tag("iu_rtag", exp_iu_rtag, iu_rtag);
      check_word("mem_rdata", exp_mem_rdata, mem_rdata);
    end
  endtask

  task automatic clear_strobes();
    iu_we_data  = '0;
    iu_we_tag   = 1'b0;
    mem_wr_beat = 1'b0;
    mem_tag_we  = 1'b0;
  endtask

  task automatic wait_iu_word(input half_data_t exp, output int n);
    n = 0;
    while (iu_rdata !== exp && n < wait_limit) begin
      step();
      n++;
    end
    if (iu_rdata !== exp) begin
      timeouts++;
      $display("timeout: iu_rdata did not show %h within %0d cycles", exp, wait_limit);
    end
  endtask

  // beat 1, one idle gap, beat 2 with the address
  task automatic send_refill(input line_addr_t a, input half_data_t b1, input half_data_t b2);
    mem_wr_beat  = 1'b1;
    mem_wdata    = b1;
    mem_wr_tid   = tid_t'($random(seed));   // ignored on beat 1
    step();
    mem_wr_beat  = 1'b0;
    step();
    mem_wr_beat  = 1'b1;
    mem_wdata    = b2;
    mem_wr_tid   = tid_of(a);
    mem_wr_index = index_of(a, 1'($random(seed)));
    step();
    mem_wr_beat  = 1'b0;
  endtask

  // --------------------
  // directed cases
  task automatic half_write_read();
    line_addr_t a;
    logic       h;
    half_data_t w;
    line_data_t old;
    a   = line_addr_t'($random(seed));
    h   = 1'($random(seed));
    w   = rand_word();
    old = m_data[a];
    iu_wr_tid   = tid_of(a);
    iu_wr_index = index_of(a, h);
    iu_wdata    = w;
    iu_we_data  = h ? 2'b10 : 2'b01;
    step();
    clear_strobes();
    iu_rd_tid   = tid_of(a);
    iu_rd_index = index_of(a, h);
    step();
    check_word("iu_rdata", w, iu_rdata);
    iu_rd_index = index_of(a, ~h);       // untouched half
    step();
    check_word("iu_rdata", h ? old[63:0] : old[127:64], iu_rdata);
  endtask

  task automatic refill_line();
    line_addr_t a;
    line_data_t old;
    int         n;
    a   = line_addr_t'($random(seed));
    old = m_data[a];
    iu_rd_tid   = tid_of(a);
    iu_rd_index = index_of(a, 1'b0);
    send_refill(a, ~old[63:0], ~old[127:64]);
    wait_iu_word(~old[63:0], n);
    assert (n == 2) else begin
      errors++;
      $display("Error at %0d ns: refill latency expected 2, got %0d", $time, n);
    end
    iu_rd_index = index_of(a, 1'b1);
    step();
    check_word("iu_rdata", ~old[127:64], iu_rdata);
  endtask

  task automatic refill_vs_iu();
    line_addr_t a;
    half_data_t b1;
    half_data_t b2;
    int         n;
    a  = line_addr_t'($random(seed));
    b1 = rand_word();
    b2 = rand_word();
    send_refill(a, b1, b2);
    iu_wr_tid   = tid_of(a);             // lands on the line write edge
    iu_wr_index = index_of(a, 1'b0);
    iu_wdata    = ~b1;
    iu_we_data  = 2'b11;
    iu_rd_tid   = tid_of(a);
    iu_rd_index = index_of(a, 1'b0);
    step();
    clear_strobes();
    wait_iu_word(b1, n);
    iu_rd_index = index_of(a, 1'b1);
    step();
    check_word("iu_rdata", b2, iu_rdata);
  endtask

  task automatic mem_read_port();
    line_addr_t a;
    half_data_t x;
    half_data_t y;
    half_data_t z;
    a = line_addr_t'($random(seed));
    x = rand_word();
    y = rand_word();
    z = rand_word();
    iu_wr_tid   = tid_of(a);
    iu_wr_index = index_of(a, 1'b0);
    iu_wdata    = x;
    iu_we_data  = 2'b01;
    step();
    iu_wdata    = y;
    iu_we_data  = 2'b10;
    step();
    clear_strobes();
    mem_rd_tid   = tid_of(a);
    mem_rd_index = index_of(a, 1'b1);
    step();
    check_word("mem_rdata", y, mem_rdata);
    mem_rd_index = index_of(a, 1'b0);
    iu_wdata     = z;                    // collides with the read
    iu_we_data   = 2'b01;
    step();
    check_word("mem_rdata", x, mem_rdata);
    clear_strobes();
    step();
    check_word("mem_rdata", z, mem_rdata);
  endtask

  task automatic tag_and_flush();
    line_addr_t a;
    tag_entry_t t;
    tag_t       g;
    a = line_addr_t'($random(seed));
    t = tag_entry_t'($random(seed));
    g = tag_t'($random(seed));
    iu_wr_tid   = tid_of(a);
    iu_wr_index = index_of(a, 1'b0);
    iu_we_tag   = 1'b1;
    iu_wtag     = t;
    step();
    clear_strobes();
    iu_rd_tid   = tid_of(a);
    iu_rd_index = index_of(a, 1'b1);
    step();
    check_tag("iu_rtag", t, iu_rtag);
    mem_tag_we   = 1'b1;
    mem_wr_tid   = tid_of(a);
    mem_wr_index = index_of(a, 1'b0);
    mem_wtag     = g;
    iu_we_tag    = 1'b1;                 // loses to the flush
    iu_wtag      = {3'b111, ~g};
    step();
    clear_strobes();
    step();
    check_tag("iu_rtag", {3'b000, g}, iu_rtag);
  endtask

  // narrow index range so ports collide often
  task automatic random_traffic();
    repeat (num_cycles) begin
      iu_rd_tid    = tid_t'($random(seed));
      iu_rd_index  = half_idx_t'($random(seed) & 32'h7);
      iu_wr_tid    = tid_t'($random(seed));
      iu_wr_index  = half_idx_t'($random(seed) & 32'h7);
      iu_wdata     = rand_word();
      iu_we_data   = (($random(seed) & 3) == 0) ? half_mask_t'($random(seed)) : '0;
      iu_we_tag    = (($random(seed) & 7) == 0);
      iu_wtag      = tag_entry_t'($random(seed));
      mem_rd_tid   = tid_t'($random(seed));
      mem_rd_index = half_idx_t'($random(seed) & 32'h7);
      mem_wr_tid   = tid_t'($random(seed));
      mem_wr_index = half_idx_t'($random(seed) & 32'h7);
      mem_wdata    = rand_word();
      mem_wr_beat  = (($random(seed) & 3) == 0);
      mem_tag_we   = (($random(seed) & 15) == 0);
      mem_wtag     = tag_t'($random(seed));
      step();
    end
    clear_strobes();
  endtask

  // --------------------
  initial begin
    seed     = 32'hbbc1_b870;
    errors   = 0;
    timeouts = 0;
    check_en = 1'b0;
    m_phase  = 1'b0;
    m_pend   = 1'b0;
    rst_n    = 1'b0;
    iu_rd_tid    = '0;
    iu_rd_index  = '0;
    iu_wr_tid    = '0;
    iu_wr_index  = '0;
    iu_wdata     = '0;
    iu_wtag      = '0;
    mem_rd_tid   = '0;
    mem_rd_index = '0;
    mem_wr_tid   = '0;
    mem_wr_index = '0;
    mem_wdata    = '0;
    mem_wtag     = '0;
    clear_strobes();
    repeat (16) @(posedge gclk);
    #1;
    rst_n = 1'b1;
    step();                              // quiet first cycle
    // every line and tag gets an address-derived pattern
    for (int i = 0; i < num_lines; i++) begin
      iu_wr_tid   = tid_of(line_addr_t'(i));
      iu_wr_index = index_of(line_addr_t'(i), 1'b0);
      iu_wdata    = {25'h0a50f0, line_addr_t'(i), 25'h13c3c0, line_addr_t'(i)};
      iu_we_data  = 2'b11;
      iu_we_tag   = 1'b1;
      iu_wtag     = {3'(i), 13'h0b7d, line_addr_t'(i)};
      step();
    end
    clear_strobes();
    step();
    check_en = 1'b1;
    half_write_read();
    refill_line();
    refill_vs_iu();
    mem_read_port();
    tag_and_flush();
    random_traffic();
    $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/dcache_ram_assertions.sv ====
// --------------------
// write path checks
// reset quiet, refill pending timing, beat phase known
// --------------------
`timescale 1ns/10ps

module dcache_ram_assertions (
  input  logic                    gclk,
  input  logic                    rst_n,
  input  logic                    beat_phase,
  input  logic                    mem_wr_beat,
  input  logic                    fill_pend,
  input  dcache_pkg::half_mask_t  iu_we_data,
  input  logic                    iu_we_tag,
  input  logic                    mem_tag_we
);

  // first cycle out of reset, nothing may write
  a_quiet_after_reset : assert property (@(posedge gclk)
    $rose(rst_n) |-> !(fill_pend || (|iu_we_data) || iu_we_tag || mem_tag_we))
    else $error("array write requested in the first cycle after reset");

  // line write only one edge after beat 2, phase back on the low half
  a_pend_after_beat2 : assert property (@(posedge gclk) disable iff (!rst_n)
    fill_pend |-> $past(mem_wr_beat && beat_phase) && !beat_phase)
    else $error("refill line write without a preceding second beat");

  a_phase_known : assert property (@(posedge gclk) disable iff (!rst_n)
    !$isunknown(beat_phase))
    else $error("refill beat phase is unknown");

endmodule

bind dcache_write_path dcache_ram_assertions u_wp_assert (
  .gclk        (gclk),
  .rst_n       (rst_n),
  .beat_phase  (beat_phase),
  .mem_wr_beat (mem_wr_beat),
  .fill_pend   (fill_pend),
  .iu_we_data  (iu_we_data),
  .iu_we_tag   (iu_we_tag),
  .mem_tag_we  (mem_tag_we)
);

// ==== logic/dcache_ram.sv ====
// --------------------
// dcache ram top
// iu and memory ports onto shared tag and data arrays
// refill and flush take priority over iu writes
// --------------------
`timescale 1ns/10ps

module dcache_ram (
  input  logic                    gclk,
  input  logic                    rst_n,
  // iu read
  input  dcache_pkg::tid_t        iu_rd_tid,
  input  dcache_pkg::half_idx_t   iu_rd_index,
  // iu write
  input  dcache_pkg::tid_t        iu_wr_tid,
  input  dcache_pkg::half_idx_t   iu_wr_index,
  input  dcache_pkg::half_data_t  iu_wdata,
  input  dcache_pkg::half_mask_t  iu_we_data,
  input  logic                    iu_we_tag,
  input  dcache_pkg::tag_entry_t  iu_wtag,
  // memory read, write-back
  input  dcache_pkg::tid_t        mem_rd_tid,
  input  dcache_pkg::half_idx_t   mem_rd_index,
  // memory write, refill beats and flush
  input  dcache_pkg::tid_t        mem_wr_tid,
  input  dcache_pkg::half_idx_t   mem_wr_index,
  input  dcache_pkg::half_data_t  mem_wdata,
  input  logic                    mem_wr_beat,
  input  logic                    mem_tag_we,
  input  dcache_pkg::tag_t        mem_wtag,
  // read results, one cycle after the address
  output dcache_pkg::half_data_t  iu_rdata,
  output dcache_pkg::tag_entry_t  iu_rtag,
  output dcache_pkg::half_data_t  mem_rdata
);

  dcache_wr_if wr_if ();    // write path to arrays
  dcache_rd_if rd_if ();    // arrays to/from formatter

  // --------------------
  dcache_write_path u_write_path (
    .gclk         (gclk),
    .rst_n        (rst_n),
    .iu_wr_tid    (iu_wr_tid),
    .iu_wr_index  (iu_wr_index),
    .iu_wdata     (iu_wdata),
    .iu_we_data   (iu_we_data),
    .iu_we_tag    (iu_we_tag),
    .iu_wtag      (iu_wtag),
    .mem_wr_tid   (mem_wr_tid),
    .mem_wr_index (mem_wr_index),
    .mem_wdata    (mem_wdata),
    .mem_wr_beat  (mem_wr_beat),
    .mem_tag_we   (mem_tag_we),
    .mem_wtag     (mem_wtag),
    .wr           (wr_if)
  );

  dcache_arrays u_arrays (
    .gclk (gclk),
    .wr   (wr_if),
    .rd   (rd_if)
  );

  dcache_read_format u_read_format (
    .gclk         (gclk),
    .rst_n        (rst_n),
    .iu_rd_tid    (iu_rd_tid),
    .iu_rd_index  (iu_rd_index),
    .mem_rd_tid   (mem_rd_tid),
    .mem_rd_index (mem_rd_index),
    .rd           (rd_if),
    .iu_rdata     (iu_rdata),
    .iu_rtag      (iu_rtag),
    .mem_rdata    (mem_rdata)
  );

endmodule

// ==== logic/dcache_read_format.sv ====
// --------------------
// dcache read formatter
// line addressing, half select, tag return
// --------------------
`timescale 1ns/10ps

module dcache_read_format (
  input  logic                    gclk,
  input  logic                    rst_n,
  input  dcache_pkg::tid_t        iu_rd_tid,
  input  dcache_pkg::half_idx_t   iu_rd_index,
  input  dcache_pkg::tid_t        mem_rd_tid,
  input  dcache_pkg::half_idx_t   mem_rd_index,
  dcache_rd_if.fmt                rd,
  output dcache_pkg::half_data_t  iu_rdata,
  output dcache_pkg::tag_entry_t  iu_rtag,
  output dcache_pkg::half_data_t  mem_rdata
);
  import dcache_pkg::*;

  logic iu_sel;    // half bit, aligned with the array output
  logic mem_sel;
  logic rd_vld;    // first read after reset has landed

  function automatic half_data_t pick_half(input line_data_t line, input logic sel);
    return sel ? line[line_w-1:half_w] : line[half_w-1:0];
  endfunction

  // line address drops the half bit
  assign rd.iu_addr  = {iu_rd_tid, iu_rd_index[index_w-1:1]};
  assign rd.mem_addr = {mem_rd_tid, mem_rd_index[index_w-1:1]};

  // --------------------
  // half select, same edge as the array read
  always_ff @(posedge gclk) begin
    if (!rst_n) begin
      iu_sel  <= 1'b0;
      mem_sel <= 1'b0;
      rd_vld  <= 1'b0;
    end else begin
      iu_sel  <= iu_rd_index[0];
      mem_sel <= mem_rd_index[0];
      rd_vld  <= 1'b1;
    end
  end

  // outputs read zero until rd_vld
  assign iu_rdata  = rd_vld ? pick_half(rd.iu_line, iu_sel)   : '0;
  assign mem_rdata = rd_vld ? pick_half(rd.mem_line, mem_sel) : '0;
  assign iu_rtag   = rd_vld ? rd.iu_tag : '0;   // valid, dirty, parity, tag

endmodule

// ==== logic/dcache_arrays.sv ====
// --------------------
// dcache storage
// data and tag arrays, one write port each, sync read ports
// --------------------
`timescale 1ns/10ps

module dcache_arrays (
  input  logic      gclk,
  dcache_wr_if.arr  wr,     // write requests from the write path
  dcache_rd_if.arr  rd      // read addresses in, raw results out
);
  import dcache_pkg::*;

  // --------------------
  // storage
  line_data_t  data_mem [num_lines];   // {high half, low half}
  tag_entry_t  tag_mem  [num_lines];

  // --------------------
  // writes

  // data, each half under its own enable
  always_ff @(posedge gclk) begin
    for (int h = 0; h < num_halves; h++) begin
      if (wr.data_we[h]) begin
        data_mem[wr.data_addr][h*half_w +: half_w] <= wr.data_line[h*half_w +: half_w];
      end
    end
  end

  // tag entry, written whole
  always_ff @(posedge gclk) begin
    if (wr.tag_we) begin
      tag_mem[wr.tag_addr] <= wr.tag_entry;
    end
  end

  // --------------------
  // read ports
  // nonblocking reads see the contents before this edge's write,
  // so a colliding read returns old data

  // iu side, line plus tag
  always_ff @(posedge gclk) begin
    rd.iu_line <= data_mem[rd.iu_addr];
    rd.iu_tag  <= tag_mem[rd.iu_addr];   // same line address as the data
  end

  // memory side, write-back reads
  always_ff @(posedge gclk) begin
    rd.mem_line <= data_mem[rd.mem_addr];
  end

endmodule

// ==== logic/dcache_write_path.sv ====
// --------------------
// dcache write path
// two beat refill deserializer, data and tag write select
// memory side wins over the iu on both arrays
// --------------------
`timescale 1ns/10ps

module dcache_write_path (
  input  logic                    gclk,
  input  logic                    rst_n,
  // iu write
  input  dcache_pkg::tid_t        iu_wr_tid,
  input  dcache_pkg::half_idx_t   iu_wr_index,
  input  dcache_pkg::half_data_t  iu_wdata,
  input  dcache_pkg::half_mask_t  iu_we_data,
  input  logic                    iu_we_tag,
  input  dcache_pkg::tag_entry_t  iu_wtag,
  // memory write
  input  dcache_pkg::tid_t        mem_wr_tid,
  input  dcache_pkg::half_idx_t   mem_wr_index,
  input  dcache_pkg::half_data_t  mem_wdata,
  input  logic                    mem_wr_beat,
  input  logic                    mem_tag_we,
  input  dcache_pkg::tag_t        mem_wtag,
  // to the arrays
  dcache_wr_if.src                wr
);
  import dcache_pkg::*;

  logic        beat_phase;    // 0 = low half comes next
  logic        first_beat;
  logic        second_beat;
  half_data_t  lo_half;       // beat 1 held here
  line_data_t  fill_line;     // rebuilt line
  line_addr_t  fill_addr;
  logic        fill_pend;     // line write owns the data port this cycle

  assign first_beat  = mem_wr_beat & ~beat_phase;
  assign second_beat = mem_wr_beat &  beat_phase;

  // --------------------
  // refill deserializer
  always_ff @(posedge gclk) begin
    if (!rst_n) begin
      beat_phase <= 1'b0;
      fill_pend  <= 1'b0;
    end else begin
      if (mem_wr_beat) begin
        beat_phase <= ~beat_phase;  // idle gaps keep the phase
      end
      fill_pend <= second_beat;     // write one edge after beat 2
    end
  end

  always_ff @(posedge gclk) begin
    if (first_beat) begin
      lo_half <= mem_wdata;
    end
    // address taken from the second beat
    if (second_beat) begin
      fill_line <= {mem_wdata, lo_half};
      fill_addr <= {mem_wr_tid, mem_wr_index[index_w-1:1]};
    end
  end

  // --------------------
  // data port select, refill over iu
  always_comb begin
    if (fill_pend) begin
      wr.data_we   = '1;                        // whole line
      wr.data_addr = fill_addr;
      wr.data_line = fill_line;
    end else begin
      wr.data_we   = iu_we_data;
      wr.data_addr = {iu_wr_tid, iu_wr_index[index_w-1:1]};
      wr.data_line = {num_halves{iu_wdata}};    // same word in both halves
    end
  end

  // tag port select, flush over iu
  always_comb begin
    if (mem_tag_we) begin
      wr.tag_we    = 1'b1;
      wr.tag_addr  = {mem_wr_tid, mem_wr_index[index_w-1:1]};
      wr.tag_entry = {3'b000, mem_wtag};        // valid, dirty, parity cleared
    end else begin
      wr.tag_we    = iu_we_tag;
      wr.tag_addr  = {iu_wr_tid, iu_wr_index[index_w-1:1]};
      wr.tag_entry = iu_wtag;
    end
  end

endmodule

// ==== logic/dcache_rd_if.sv ====
// --------------------
// dcache read bundle
// read addresses out to the arrays, raw lines and tag back
// --------------------
`timescale 1ns/10ps

interface dcache_rd_if;

  // addresses, set up before the edge
  dcache_pkg::line_addr_t  iu_addr;
  dcache_pkg::line_addr_t  mem_addr;

  // registered results, one cycle later
  dcache_pkg::line_data_t  iu_line;
  dcache_pkg::line_data_t  mem_line;
  dcache_pkg::tag_entry_t  iu_tag;     // tag follows the iu address only

  // formatter side
  modport fmt (
    output iu_addr, mem_addr,
    input  iu_line, mem_line, iu_tag
  );

  // storage side
  modport arr (
    input  iu_addr, mem_addr,
    output iu_line, mem_line, iu_tag
  );

endinterface

// ==== logic/dcache_wr_if.sv ====
// --------------------
// dcache write request bundle
// data and tag array writes, applied at the next gclk edge
// --------------------
`timescale 1ns/10ps

interface dcache_wr_if;

  // data array port
  dcache_pkg::half_mask_t  data_we;    // per half enable
  dcache_pkg::line_addr_t  data_addr;
  dcache_pkg::line_data_t  data_line;

  // tag array port
  logic                    tag_we;
  dcache_pkg::line_addr_t  tag_addr;
  dcache_pkg::tag_entry_t  tag_entry;

  // write path side
  modport src (
    output data_we, data_addr, data_line,
    output tag_we, tag_addr, tag_entry
  );

  // storage side
  modport arr (
    input  data_we, data_addr, data_line,
    input  tag_we, tag_addr, tag_entry
  );

endinterface

// ==== logic/dcache_pkg.sv ====
// --------------------
// dcache ram package
// geometry and vector types for the data cache ram
// --------------------
package dcache_pkg;

  // --------------------
  // geometry
  localparam int tid_w      = 2;                 // hw threads
  localparam int line_idx_w = 5;                 // lines per thread
  localparam int index_w    = line_idx_w + 1;    // lsb picks the half
  localparam int half_w     = 64;                // iu / memory beat width
  localparam int num_halves = 2;
  localparam int line_w     = num_halves * half_w;
  localparam int tag_w      = 20;                // tag address field

  // all threads share one array, tid on top of the line index
  localparam int num_lines  = 2 ** (tid_w + line_idx_w);

  // --------------------
  // vector types
  typedef logic [tid_w-1:0]              tid_t;
  typedef logic [index_w-1:0]            half_idx_t;   // line index plus half bit
  typedef logic [tid_w+line_idx_w-1:0]   line_addr_t;  // {tid, line index}

  typedef logic [half_w-1:0]             half_data_t;
  typedef logic [line_w-1:0]             line_data_t;  // {high half, low half}
  typedef logic [num_halves-1:0]         half_mask_t;  // bit 0 is the low half

  typedef logic [tag_w-1:0]              tag_t;

  // tag entry, msb first
  //   valid
  //   dirty
  //   parity, stored as given
  //   tag address
  typedef logic [tag_w+2:0]              tag_entry_t;

endpackage
